// ==== rtl/lsu_ahb_pkg.sv ====
`default_nettype none

package lsu_ahb_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // only single transfers are issued
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    // word transfers only
    localparam logic [2:0] HSIZE_WORD = 3'b010;

    // request sequencer states
    localparam int ST_W = 3;

    localparam logic [ST_W-1:0] ST_IDLE    = 3'd0;
    localparam logic [ST_W-1:0] ST_RD_ADDR = 3'd1;
    localparam logic [ST_W-1:0] ST_RD_DATA = 3'd2;
    localparam logic [ST_W-1:0] ST_WR_ADDR = 3'd3;
    localparam logic [ST_W-1:0] ST_WR_DATA = 3'd4;
    localparam logic [ST_W-1:0] ST_DONE    = 3'd5;

endpackage

`default_nettype wire

// ==== rtl/ahb_xfer_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_xfer_fsm
    import lsu_ahb_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    // lsu request
    input  logic            re_i,
    input  logic            we_i,

    // pipeline control
    input  logic            stall_i,
    input  logic            flush_i,

    // bus handshake
    input  logic            hready_i,

    output logic [ST_W-1:0] state_o,
    output logic            ld_rd_o,
    output logic            ld_wr_o,
    output logic            stallreq_o
);

    logic [ST_W-1:0] state;
    logic [ST_W-1:0] next_state;
    logic            ld_rd;
    logic            ld_wr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // read:       IDLE -> RD_ADDR -> RD_DATA -> DONE
    // write:      IDLE -> WR_ADDR -> WR_DATA -> DONE
    // read-write: IDLE -> RD_ADDR -> RD_DATA -> WR_ADDR -> WR_DATA -> DONE
    always_comb begin
        next_state = state;
        ld_rd      = 1'b0;
        ld_wr      = 1'b0;

        if (flush_i) begin
            next_state = ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    // read goes first when both are requested
                    if (re_i && hready_i) begin
                        ld_rd      = 1'b1;
                        next_state = ST_RD_ADDR;
                    end else if (we_i && hready_i) begin
                        ld_wr      = 1'b1;
                        next_state = ST_WR_ADDR;
                    end
                end
                ST_RD_ADDR: begin
                    if (hready_i) begin
                        next_state = ST_RD_DATA;
                    end
                end
                ST_RD_DATA: begin
                    if (hready_i) begin
                        if (we_i) begin
                            ld_wr      = 1'b1;
                            next_state = ST_WR_ADDR;
                        end else begin
                            next_state = ST_DONE;
                        end
                    end
                end
                ST_WR_ADDR: begin
                    if (hready_i) begin
                        next_state = ST_WR_DATA;
                    end
                end
                ST_WR_DATA: begin
                    if (hready_i) begin
                        next_state = ST_DONE;
                    end
                end
                ST_DONE: begin
                    // hold the result while the pipeline is stalled
                    if (!stall_i) begin
                        next_state = ST_IDLE;
                    end
                end
                default: begin
                    next_state = ST_IDLE;
                end
            endcase
        end
    end

    // stall the pipeline until the transfer has finished
    always_comb begin
        stallreq_o = 1'b0;
        if (!flush_i) begin
            case (state)
                ST_IDLE:  stallreq_o = re_i | we_i;
                ST_DONE:  stallreq_o = 1'b0;
                default:  stallreq_o = 1'b1;
            endcase
        end
    end

    assign state_o = state;
    assign ld_rd_o = ld_rd;
    assign ld_wr_o = ld_wr;

endmodule

`default_nettype wire

// ==== rtl/ahb_master_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_master_datapath
    import lsu_ahb_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // from the sequencer
    input  logic [ST_W-1:0]   state_i,
    input  logic              ld_rd_i,
    input  logic              ld_wr_i,

    // lsu request payload
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0] wdata_i,

    // slave response
    input  logic              hready_i,
    input  logic [DATA_W-1:0] hrdata_i,

    output logic [1:0]        htrans_o,
    output logic [ADDR_W-1:0] haddr_o,
    output logic              hwrite_o,
    output logic [2:0]        hsize_o,
    output logic [DATA_W-1:0] hwdata_o,
    output logic [DATA_W-1:0] rdata_o
);

    logic [1:0]        htrans_q;
    logic [ADDR_W-1:0] haddr_q;
    logic              hwrite_q;
    logic [DATA_W-1:0] wdata_stage;
    logic [DATA_W-1:0] hwdata_q;
    logic [DATA_W-1:0] rdata_q;
    logic              in_addr_phase;
    logic              wr_addr_done;
    logic              rd_data_done;

    assign in_addr_phase = (state_i == ST_RD_ADDR) || (state_i == ST_WR_ADDR);
    assign wr_addr_done  = (state_i == ST_WR_ADDR) && hready_i;
    assign rd_data_done  = (state_i == ST_RD_DATA) && hready_i;

    // address phase control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            htrans_q <= HTRANS_IDLE;
            haddr_q  <= '0;
            hwrite_q <= 1'b0;
        end else if (ld_rd_i || ld_wr_i) begin
            htrans_q <= HTRANS_NONSEQ;
            haddr_q  <= addr_i;
            hwrite_q <= ld_wr_i;
        end else if (htrans_q == HTRANS_NONSEQ && (hready_i || !in_addr_phase)) begin
            // accepted, or dropped after a flush
            htrans_q <= HTRANS_IDLE;
        end
    end

    // write word waits here until its address phase is accepted
    always_ff @(posedge clk) begin
        if (ld_wr_i) begin
            wdata_stage <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_addr_done) begin
            hwdata_q <= wdata_stage;
        end
    end

    // read word is held until the next completed read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (rd_data_done) begin
            rdata_q <= hrdata_i;
        end
    end

    assign htrans_o = htrans_q;
    assign haddr_o  = haddr_q;
    assign hwrite_o = hwrite_q;
    assign hsize_o  = HSIZE_WORD;
    assign hwdata_o = hwdata_q;
    assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

// ==== rtl/lsu_ahb_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_ahb_master
    import lsu_ahb_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // load/store unit
    input  logic              re_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic [DATA_W-1:0] rdata_o,

    // pipeline control
    input  logic              stall_i,
    input  logic              flush_i,
    output logic              stallreq_o,

    // ahb-lite master
    output logic [1:0]        htrans_o,
    output logic [ADDR_W-1:0] haddr_o,
    output logic              hwrite_o,
    output logic [2:0]        hsize_o,
    output logic [DATA_W-1:0] hwdata_o,
    input  logic              hready_i,
    input  logic              hresp_i,
    input  logic [DATA_W-1:0] hrdata_i
);

    logic [ST_W-1:0] state;
    logic            ld_rd;
    logic            ld_wr;

    // hresp_i is ignored so an error completes like OK

    ahb_xfer_fsm u_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .re_i       (re_i),
        .we_i       (we_i),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .hready_i   (hready_i),
        .state_o    (state),
        .ld_rd_o    (ld_rd),
        .ld_wr_o    (ld_wr),
        .stallreq_o (stallreq_o)
    );

    ahb_master_datapath u_datapath (
        .clk      (clk),
        .rst_n    (rst_n),
        .state_i  (state),
        .ld_rd_i  (ld_rd),
        .ld_wr_i  (ld_wr),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .hready_i (hready_i),
        .hrdata_i (hrdata_i),
        .htrans_o (htrans_o),
        .haddr_o  (haddr_o),
        .hwrite_o (hwrite_o),
        .hsize_o  (hsize_o),
        .hwdata_o (hwdata_o),
        .rdata_o  (rdata_o)
    );

endmodule

`default_nettype wire

// ==== verif/lsu_ahb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_ahb_checker
    import lsu_ahb_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    // expected values from the stimulus
    input  logic              vec_start_i,
    input  logic              vec_end_i,
    input  int                vec_id_i,
    input  logic [1:0]        exp_op_i,
    input  logic [ADDR_W-1:0] exp_addr_i,
    input  logic [DATA_W-1:0] exp_wdata_i,
    input  logic [DATA_W-1:0] exp_rdata_i,
    // watched dut ports
    input  logic              stall_i,
    input  logic              flush_i,
    input  logic              stallreq_i,
    input  logic [DATA_W-1:0] rdata_i,
    input  logic [1:0]        htrans_i,
    input  logic [ADDR_W-1:0] haddr_i,
    input  logic              hwrite_i,
    input  logic [2:0]        hsize_i,
    input  logic [DATA_W-1:0] hwdata_i,
    input  logic              hready_i,
    output int                pass_count_o,
    output int                fail_count_o
);

    int   test_id;
    int   errors;
    int   n_rd;
    int   n_wr;
    int   exp_rd;
    int   exp_wr;
    logic reset_done;
    logic active;
    logic flushed;
    logic dp_busy;
    logic dp_write;

    task automatic check_word(input string sig, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch test %0d %s: got %h expected %h", test_id, sig, got, exp);
            errors++;
        end
    endtask

    task automatic close_test();
        if (errors == 0) begin
            $display("test %0d: pass", test_id);
            pass_count_o++;
        end else begin
            $display("test %0d: FAIL with %0d errors", test_id, errors);
            fail_count_o++;
        end
    endtask

    // dut outputs sampled at the rising edge before they update
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pass_count_o = 0;
            fail_count_o = 0;
            reset_done   = 1'b0;
            active       = 1'b0;
            dp_busy      = 1'b0;
            dp_write     = 1'b0;
        end else begin
            if (!reset_done) begin
                // idle bus and cleared read word out of reset
                reset_done = 1'b1;
                test_id    = 0;
                errors     = 0;
                check_word("htrans_o", 32'(htrans_i), 32'(HTRANS_IDLE));
                check_word("hwrite_o", 32'(hwrite_i), 32'h0);
                check_word("stallreq_o", 32'(stallreq_i), 32'h0);
                check_word("rdata_o", rdata_i, 32'h0);
                close_test();
            end
            if (vec_start_i) begin
                active  = 1'b1;
                flushed = flush_i;
                test_id = vec_id_i;
                errors  = 0;
                n_rd    = 0;
                n_wr    = 0;
            end
            if (dp_busy) begin
                if (dp_write) begin
                    check_word("hwdata_o", hwdata_i, exp_wdata_i);
                end
                dp_busy = !hready_i;
            end
            // accepted address phase
            if (htrans_i == HTRANS_NONSEQ && hready_i) begin
                dp_busy  = 1'b1;
                dp_write = hwrite_i;
                if (!active) begin
                    $display("transfer to %h started outside any request", haddr_i);
                    fail_count_o++;
                end else begin
                    check_word("haddr_o", haddr_i, exp_addr_i);
                    check_word("hsize_o", 32'(hsize_i), 32'(HSIZE_WORD));
                    if (hwrite_i && exp_op_i == 2'd3 && n_rd == 0) begin
                        $display("test %0d: write issued before its read", test_id);
                        errors++;
                    end
                    if (hwrite_i) begin
                        n_wr++;
                    end else begin
                        n_rd++;
                    end
                end
            end
            if (active) begin
                if (flush_i || stall_i || vec_end_i) begin
                    check_word("stallreq_o", 32'(stallreq_i), 32'h0);
                end else begin
                    check_word("stallreq_o", 32'(stallreq_i), 32'h1);
                end
                if (stall_i || vec_end_i) begin
                    check_word("rdata_o", rdata_i, exp_rdata_i);
                end
                if (vec_end_i) begin
                    exp_rd = (exp_op_i[0] && !flushed) ? 1 : 0;
                    exp_wr = (exp_op_i[1] && !flushed) ? 1 : 0;
                    if (n_rd != exp_rd || n_wr != exp_wr) begin
                        $display("test %0d: %0d reads and %0d writes, expected %0d and %0d",
                                 test_id, n_rd, n_wr, exp_rd, exp_wr);
                        errors++;
                    end
                    close_test();
                    active = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_lsu_ahb_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_ahb_master
    import lsu_ahb_pkg::*;
();

    localparam int NUM_VECTORS    = 20;
    localparam int MEM_DEPTH      = 64;
    localparam int MEM_AW         = $clog2(MEM_DEPTH);
    localparam int TIMEOUT_MARGIN = 20;

    logic              clk;
    logic              rst_n;
    logic              re;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              stall;
    logic              flush;
    logic [DATA_W-1:0] rdata;
    logic              stallreq;
    logic [1:0]        htrans;
    logic [ADDR_W-1:0] haddr;
    logic              hwrite;
    logic [2:0]        hsize;
    logic [DATA_W-1:0] hwdata;
    logic              hready;
    logic              hresp;
    logic [DATA_W-1:0] hrdata;

    // expectations handed to the checker
    logic              vec_start;
    logic              vec_end;
    int                vec_id;
    logic [1:0]        exp_op;
    logic [ADDR_W-1:0] exp_addr;
    logic [DATA_W-1:0] exp_wdata;
    logic [DATA_W-1:0] exp_rdata;
    int                pass_count;
    int                fail_count;

    logic [1:0]        v_op    [NUM_VECTORS];
    logic [ADDR_W-1:0] v_addr  [NUM_VECTORS];
    logic [DATA_W-1:0] v_wdata [NUM_VECTORS];
    int                v_waits [NUM_VECTORS];
    int                v_stall [NUM_VECTORS];
    logic              v_flush [NUM_VECTORS];
    logic [DATA_W-1:0] v_rdata [NUM_VECTORS];
    int                n_vec;
    int                cycle_limit;
    int                cycle_count;
    logic              limit_ready;

    // slave model state
    logic [DATA_W-1:0] mem [MEM_DEPTH];
    int                cur_waits;
    int                waits_left;
    logic              dp_busy;
    logic              dp_write;
    logic [MEM_AW-1:0] dp_idx;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    lsu_ahb_master UUT (
        .clk(clk), .rst_n(rst_n), .re_i(re), .we_i(we), .addr_i(addr), .wdata_i(wdata),
        .rdata_o(rdata), .stall_i(stall), .flush_i(flush), .stallreq_o(stallreq),
        .htrans_o(htrans), .haddr_o(haddr), .hwrite_o(hwrite), .hsize_o(hsize),
        .hwdata_o(hwdata), .hready_i(hready), .hresp_i(hresp), .hrdata_i(hrdata)
    );

    lsu_ahb_checker u_checker (
        .clk(clk), .rst_n(rst_n), .vec_start_i(vec_start), .vec_end_i(vec_end),
        .vec_id_i(vec_id), .exp_op_i(exp_op), .exp_addr_i(exp_addr),
        .exp_wdata_i(exp_wdata), .exp_rdata_i(exp_rdata), .stall_i(stall), .flush_i(flush),
        .stallreq_i(stallreq), .rdata_i(rdata), .htrans_i(htrans), .haddr_i(haddr),
        .hwrite_i(hwrite), .hsize_i(hsize), .hwdata_i(hwdata), .hready_i(hready),
        .pass_count_o(pass_count), .fail_count_o(fail_count)
    );

    // a write commits only when its data phase completes
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dp_busy    <= 1'b0;
            dp_write   <= 1'b0;
            dp_idx     <= '0;
            waits_left <= 0;
        end else if (hready) begin
            if (dp_busy && dp_write) begin
                mem[dp_idx] = hwdata;
            end
            dp_busy    <= (htrans == HTRANS_NONSEQ);
            dp_write   <= hwrite;
            dp_idx     <= haddr[MEM_AW+1:2];
            waits_left <= cur_waits;
        end else if (waits_left > 0) begin
            waits_left <= waits_left - 1;
        end
    end

    always @(negedge clk) begin
        hready = !(dp_busy && waits_left != 0);
        hrdata = (dp_busy && !dp_write) ? mem[dp_idx] : '0;
    end

    // low half of each word is its byte address
    task automatic fill_memory();
        for (int k = 0; k < MEM_DEPTH; k++) begin
            mem[k] = 32'hbeef_0000 | 32'(k * 4);
        end
    endtask

    task automatic load_vectors(output logic ok);
        int          fd;
        int          cnt;
        int          max_waits;
        int          max_stall;
        string       line;
        byte         first;
        logic [31:0] t_op, t_addr, t_wdata, t_waits, t_stall, t_flush, t_rdata;
        ok        = 1'b0;
        n_vec     = 0;
        max_waits = 0;
        max_stall = 0;
        fd = $fopen("verif/lsu_ahb_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/lsu_ahb_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cnt = $fgets(line, fd);
                first = (line.len() > 0) ? line.getc(0) : 8'h23;
                // lines starting with # are comments
                if (first != 8'h23) begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h", t_op, t_addr, t_wdata,
                                  t_waits, t_stall, t_flush, t_rdata);
                    if (cnt == 7 && n_vec < NUM_VECTORS) begin
                        v_op[n_vec]    = t_op[1:0];
                        v_addr[n_vec]  = t_addr;
                        v_wdata[n_vec] = t_wdata;
                        v_waits[n_vec] = int'(t_waits);
                        v_stall[n_vec] = int'(t_stall);
                        v_flush[n_vec] = t_flush[0];
                        v_rdata[n_vec] = t_rdata;
                        max_waits = (int'(t_waits) > max_waits) ? int'(t_waits) : max_waits;
                        max_stall = (int'(t_stall) > max_stall) ? int'(t_stall) : max_stall;
                    end
                    if (cnt == 7) begin
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
            if (n_vec != NUM_VECTORS) begin
                $display("vector file holds %0d requests, %0d expected", n_vec, NUM_VECTORS);
            end else begin
                ok = 1'b1;
                cycle_limit = n_vec * (12 + 2 * max_waits + max_stall) + TIMEOUT_MARGIN;
            end
        end
    endtask

    // request held until done, then stall cycles, or dropped by a flush
    task automatic run_request(input int i);
        vec_id    = i + 1;
        exp_op    = v_op[i];
        exp_addr  = v_addr[i];
        exp_wdata = v_wdata[i];
        exp_rdata = v_rdata[i];
        cur_waits = v_waits[i];
        re        = v_op[i][0];
        we        = v_op[i][1];
        addr      = v_addr[i];
        wdata     = v_wdata[i];
        flush     = v_flush[i];
        vec_start = 1'b1;
        @(negedge clk);
        vec_start = 1'b0;
        if (!v_flush[i]) begin
            while (stallreq) begin
                @(negedge clk);
            end
            re    = 1'b0;
            we    = 1'b0;
            stall = (v_stall[i] > 0);
            repeat (v_stall[i]) @(negedge clk);
        end
        re      = 1'b0;
        we      = 1'b0;
        flush   = 1'b0;
        stall   = 1'b0;
        vec_end = 1'b1;
        @(negedge clk);
        vec_end = 1'b0;
    endtask

    initial begin
        logic ok;
        int   gap;
        void'($urandom(56));
        rst_n       = 1'b0;
        re          = 1'b0;
        we          = 1'b0;
        addr        = '0;
        wdata       = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        hready      = 1'b1;
        hresp       = 1'b0;
        hrdata      = '0;
        vec_start   = 1'b0;
        vec_end     = 1'b0;
        vec_id      = 0;
        exp_op      = '0;
        exp_addr    = '0;
        exp_wdata   = '0;
        exp_rdata   = '0;
        cur_waits   = 0;
        cycle_limit = 0;
        limit_ready = 1'b0;
        fill_memory();
        load_vectors(ok);
        if (!ok) begin
            $display("Simulation failed");
            $finish;
        end else begin
            limit_ready = 1'b1;
            repeat (4) @(negedge clk);
            rst_n = 1'b1;
            repeat (2) @(negedge clk);
            for (int i = 0; i < n_vec; i++) begin
                gap = int'($urandom_range(3, 0));
                repeat (gap) @(negedge clk);
                run_request(i);
            end
            repeat (2) @(negedge clk);
            $display("tests: %0d passed, %0d failed", pass_count, fail_count);
            if (fail_count == 0 && pass_count == n_vec + 1) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    initial begin
        cycle_count = 0;
        wait (limit_ready);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not end within %0d clock cycles", cycle_limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/lsu_ahb_vectors.txt ====
# op (1 read, 2 write, 3 read then write), addr, wdata, waits, stall, flush, exp rdata_o
# all hex; stall counts cycles held in done, exp rdata_o is checked when the request ends
1 00000010 00000000 0 0 0 beef0010
2 00000020 11223344 0 0 0 beef0010
1 00000020 00000000 0 0 0 11223344
2 00000024 a5a5a5a5 2 0 0 11223344
1 00000024 00000000 3 0 0 a5a5a5a5
3 00000030 cafef00d 0 0 0 beef0030
1 00000030 00000000 1 0 0 cafef00d
3 00000034 5555aaaa 3 0 0 beef0034
1 00000034 00000000 0 0 0 5555aaaa
1 00000040 00000000 0 4 0 beef0040
2 00000044 0badc0de 1 3 0 beef0040
1 00000044 00000000 2 2 0 0badc0de
2 00000020 deadbeef 0 0 1 0badc0de
1 00000020 00000000 0 0 0 11223344
1 00000050 00000000 5 0 0 beef0050
2 00000054 12345678 5 1 0 beef0050
3 00000054 87654321 4 2 0 12345678
1 00000054 00000000 2 0 0 87654321
1 00000060 00000000 0 0 1 87654321
1 000000fc 00000000 1 0 0 beef00fc

// ==== lsu_ahb_master.f ====
rtl/lsu_ahb_pkg.sv
rtl/ahb_xfer_fsm.sv
rtl/ahb_master_datapath.sv
rtl/lsu_ahb_master.sv
verif/lsu_ahb_checker.sv
verif/tb_lsu_ahb_master.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_lsu_ahb_master
FILELIST  = lsu_ahb_master.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
